// File: hdl/rv64_pkg.sv
// word types, opcode and control encodings, decoded-control and memory-request structs, reset vector
package rv64_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;
  localparam xlen_t XLEN_MIN = {1'b1, 63'b0};

  // major opcodes
  localparam opcode_t OPC_LUI       = 7'b0110111;
  localparam opcode_t OPC_AUIPC     = 7'b0010111;
  localparam opcode_t OPC_JAL       = 7'b1101111;
  localparam opcode_t OPC_JALR      = 7'b1100111;
  localparam opcode_t OPC_BRANCH    = 7'b1100011;
  localparam opcode_t OPC_LOAD      = 7'b0000011;
  localparam opcode_t OPC_STORE     = 7'b0100011;
  localparam opcode_t OPC_OP_IMM    = 7'b0010011;
  localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_OP        = 7'b0110011;
  localparam opcode_t OPC_OP_32     = 7'b0111011;
  localparam opcode_t OPC_SYSTEM    = 7'b1110011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'b00000,
    ALU_SLL      = 5'b00001,
    ALU_SLT      = 5'b00010,
    ALU_COPY_IMM = 5'b00011,
    ALU_XOR      = 5'b00100,
    ALU_SRL      = 5'b00101,
    ALU_OR       = 5'b00110,
    ALU_AND      = 5'b00111,
    ALU_SUB      = 5'b01000,
    ALU_SLTU     = 5'b01010,
    ALU_SRA      = 5'b01101,
    ALU_REMU     = 5'b11001,
    ALU_DIVU     = 5'b11010,
    ALU_DIV      = 5'b11011,
    ALU_MUL      = 5'b11100,
    ALU_REM      = 5'b11101
  } alu_op_e;

  // nine kinds need four bits
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_BEQ  = 4'b0100,
    BR_BNE  = 4'b0101,
    BR_BLT  = 4'b0110,
    BR_BGE  = 4'b0111,
    BR_BLTU = 4'b1110,
    BR_BGEU = 4'b1111
  } branch_e;

  typedef enum logic [0:0] {
    ASRC_RS1 = 1'b0,
    ASRC_PC  = 1'b1
  } asrc_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } bsrc_e;

  // bits [2:1] give the access size
  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    asrc_e   asrc;
    bsrc_e   bsrc;
    logic    word_cut;
    branch_e branch;
    mem_op_e mem_op;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    reg_write;
    logic    halt;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    xlen_t      addr;
    xlen_t      wdata;
    logic [1:0] size;
    logic       re;
    logic       we;
  } mem_req_t;

  localparam ctrl_t CTRL_NOP = '{
    alu_op: ALU_ADD, asrc: ASRC_RS1, bsrc: BSRC_RS2, word_cut: 1'b0,
    branch: BR_NONE, mem_op: MEM_LD, mem_read: 1'b0, mem_write: 1'b0,
    mem_to_reg: 1'b0, reg_write: 1'b0, halt: 1'b0, illegal: 1'b0
  };

endpackage

// File: hdl/rv64_idu.sv
// RV64IM instruction decoder with immediate generation and control decode
`timescale 1ns/1ps

module rv64_idu import rv64_pkg::*; (
  input  inst_t    i_inst,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output reg_idx_t o_rd,
  output xlen_t    o_imm,
  output ctrl_t    o_ctrl
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OPC_STORE:           o_imm = imm_s;
      OPC_BRANCH:          o_imm = imm_b;
      OPC_LUI, OPC_AUIPC:  o_imm = imm_u;
      OPC_JAL:             o_imm = imm_j;
      default:             o_imm = imm_i;
    endcase
  end

  // shared funct3 map of op and op-imm
  function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e muldiv_op(input logic [2:0] f3);
    case (f3)
      3'b100:  return ALU_DIV;
      3'b101:  return ALU_DIVU;
      3'b110:  return ALU_REM;
      3'b111:  return ALU_REMU;
      default: return ALU_MUL;
    endcase
  endfunction

  always_comb begin
    o_ctrl = CTRL_NOP;
    bad    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_ctrl.alu_op    = ALU_COPY_IMM;
        o_ctrl.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        o_ctrl.asrc      = ASRC_PC;
        o_ctrl.bsrc      = BSRC_IMM;
        o_ctrl.reg_write = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // link value pc + 4 through the adder
        o_ctrl.asrc      = ASRC_PC;
        o_ctrl.bsrc      = BSRC_FOUR;
        o_ctrl.branch    = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        o_ctrl.reg_write = 1'b1;
        bad              = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_ctrl.alu_op = ALU_SUB;
        case (funct3)
          3'b000:  o_ctrl.branch = BR_BEQ;
          3'b001:  o_ctrl.branch = BR_BNE;
          3'b100:  o_ctrl.branch = BR_BLT;
          3'b101:  o_ctrl.branch = BR_BGE;
          3'b110:  o_ctrl.branch = BR_BLTU;
          3'b111:  o_ctrl.branch = BR_BGEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        o_ctrl.bsrc       = BSRC_IMM;
        o_ctrl.mem_read   = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.reg_write  = 1'b1;
        case (funct3)
          3'b000:  o_ctrl.mem_op = MEM_LB;
          3'b001:  o_ctrl.mem_op = MEM_LH;
          3'b010:  o_ctrl.mem_op = MEM_LW;
          3'b011:  o_ctrl.mem_op = MEM_LD;
          3'b100:  o_ctrl.mem_op = MEM_LBU;
          3'b101:  o_ctrl.mem_op = MEM_LHU;
          3'b110:  o_ctrl.mem_op = MEM_LWU;
          default: bad = 1'b1;
        endcase
      end
      OPC_STORE: begin
        o_ctrl.bsrc      = BSRC_IMM;
        o_ctrl.mem_write = 1'b1;
        // size lands in mem_op[2:1]
        o_ctrl.mem_op    = mem_op_e'({funct3[1:0], 1'b0});
        bad              = funct3[2];
      end
      OPC_OP_IMM: begin
        o_ctrl.bsrc      = BSRC_IMM;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_op    = base_op(funct3, (funct3 == 3'b101) && i_inst[30]);
        if (funct3 == 3'b001) begin
          bad = (i_inst[31:26] != 6'b000000);
        end else if (funct3 == 3'b101) begin
          bad = (i_inst[31:26] != 6'b000000) && (i_inst[31:26] != 6'b010000);
        end
      end
      OPC_OP_IMM_32: begin
        o_ctrl.bsrc      = BSRC_IMM;
        o_ctrl.word_cut  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_op    = base_op(funct3, (funct3 == 3'b101) && i_inst[30]);
        case (funct3)
          3'b000:  bad = 1'b0;
          3'b001:  bad = (funct7 != F7_BASE);
          3'b101:  bad = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          default: bad = 1'b1;
        endcase
      end
      OPC_OP, OPC_OP_32: begin
        o_ctrl.word_cut  = (opcode == OPC_OP_32);
        o_ctrl.reg_write = 1'b1;
        if (funct7 == F7_MULDIV) begin
          o_ctrl.alu_op = muldiv_op(funct3);
          // mulh variants are not supported
          bad = (funct3 != 3'b000) && !funct3[2];
        end else if (funct7 == F7_ALT) begin
          o_ctrl.alu_op = base_op(funct3, 1'b1);
          bad = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else if (funct7 == F7_BASE) begin
          o_ctrl.alu_op = base_op(funct3, 1'b0);
          // word form only has add, sll, srl
          bad = (opcode == OPC_OP_32) && (funct3 != 3'b000) && (funct3 != 3'b001)
                && (funct3 != 3'b101);
        end else begin
          bad = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        if (i_inst == INST_EBREAK) begin
          o_ctrl.halt = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase

    // illegal encodings retire as a no-op
    if (bad) begin
      o_ctrl         = CTRL_NOP;
      o_ctrl.illegal = 1'b1;
    end
  end

endmodule

// File: hdl/rv64_regfile.sv
// 32 x 64-bit register file, two async read ports, one sync write port, x0 tied to zero
`timescale 1ns/1ps

module rv64_regfile import rv64_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  reg_idx_t i_rd,
  input  logic     i_we,
  input  xlen_t    i_wdata,
  output xlen_t    o_rdata1,
  output xlen_t    o_rdata2
);

  // x0 is cleared in reset and never written
  xlen_t regs [0:31];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_rs1];
  assign o_rdata2 = regs[i_rs2];

  a_x0_zero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((i_rs1 != '0) || (o_rdata1 == '0)) && ((i_rs2 != '0) || (o_rdata2 == '0))
  ) else $error("regfile: x0 read back nonzero");

endmodule

// File: hdl/rv64_exu.sv
// execute unit with operand select, ALU, branch resolve, next pc, load extension, write-back mux
`timescale 1ns/1ps

module rv64_exu import rv64_pkg::*; (
  input  ctrl_t i_ctrl,
  input  xlen_t i_rs1,
  input  xlen_t i_rs2,
  input  xlen_t i_imm,
  input  xlen_t i_pc,
  input  xlen_t i_rdata,
  output xlen_t o_alu_result,
  output xlen_t o_next_pc,
  output xlen_t o_wb_data
);

  xlen_t             src_a, src_b;
  xlen_t             a_s, b_s, a_u, b_u;
  logic [5:0]        shamt;
  logic              lt_s, lt_u;
  logic signed [63:0] sra_res;
  logic signed [63:0] sdiv_q, sdiv_r;
  logic              div_zero, div_ovf;
  xlen_t             quot_s, rem_s, quot_u, rem_u;
  xlen_t             result;
  logic              br_eq, br_lt, br_ltu, taken;
  xlen_t             jalr_sum, target;
  xlen_t             load_data;

  assign src_a = (i_ctrl.asrc == ASRC_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.bsrc)
      BSRC_RS2: src_b = i_rs2;
      BSRC_IMM: src_b = i_imm;
      default:  src_b = 64'd4;
    endcase
  end

  // word ops see the low 32 bits in signed and unsigned views
  assign a_s = i_ctrl.word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign b_s = i_ctrl.word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;
  assign a_u = i_ctrl.word_cut ? {32'b0, src_a[31:0]} : src_a;
  assign b_u = i_ctrl.word_cut ? {32'b0, src_b[31:0]} : src_b;

  assign shamt = i_ctrl.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  assign lt_s    = $signed(a_s) < $signed(b_s);
  assign lt_u    = a_u < b_u;
  assign sra_res = $signed(a_s) >>> shamt;

  // divide corner cases per the ISA
  assign div_zero = (b_u == '0);
  assign div_ovf  = (a_s == XLEN_MIN) && (b_s == '1);
  assign sdiv_q   = $signed(a_s) / $signed(b_s);
  assign sdiv_r   = $signed(a_s) % $signed(b_s);

  always_comb begin
    if (div_zero) begin
      quot_s = '1;
      rem_s  = a_s;
    end else if (div_ovf) begin
      quot_s = a_s;
      rem_s  = '0;
    end else begin
      quot_s = sdiv_q;
      rem_s  = sdiv_r;
    end
  end

  assign quot_u = div_zero ? '1 : (a_u / b_u);
  assign rem_u  = div_zero ? a_u : (a_u % b_u);

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:      result = a_s + b_s;
      ALU_SUB:      result = a_s - b_s;
      ALU_SLT:      result = {63'b0, lt_s};
      ALU_SLTU:     result = {63'b0, lt_u};
      ALU_XOR:      result = a_s ^ b_s;
      ALU_OR:       result = a_s | b_s;
      ALU_AND:      result = a_s & b_s;
      ALU_SLL:      result = a_s << shamt;
      ALU_SRL:      result = a_u >> shamt;
      ALU_SRA:      result = sra_res;
      ALU_COPY_IMM: result = i_imm;
      ALU_MUL:      result = a_s * b_s;
      ALU_DIV:      result = quot_s;
      ALU_DIVU:     result = quot_u;
      ALU_REM:      result = rem_s;
      ALU_REMU:     result = rem_u;
      default:      result = '0;
    endcase
  end

  // word results sign-extend from bit 31
  assign o_alu_result = i_ctrl.word_cut ? {{32{result[31]}}, result[31:0]} : result;

  assign br_eq  = (i_rs1 == i_rs2);
  assign br_lt  = $signed(i_rs1) < $signed(i_rs2);
  assign br_ltu = i_rs1 < i_rs2;

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_BEQ:          taken = br_eq;
      BR_BNE:          taken = !br_eq;
      BR_BLT:          taken = br_lt;
      BR_BGE:          taken = !br_lt;
      BR_BLTU:         taken = br_ltu;
      BR_BGEU:         taken = !br_ltu;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_sum  = i_rs1 + i_imm;
  assign target    = (i_ctrl.branch == BR_JALR) ? {jalr_sum[63:1], 1'b0} : (i_pc + i_imm);
  assign o_next_pc = taken ? target : (i_pc + 64'd4);

  always_comb begin
    case (i_ctrl.mem_op)
      MEM_LB:  load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      MEM_LBU: load_data = {56'b0, i_rdata[7:0]};
      MEM_LH:  load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      MEM_LHU: load_data = {48'b0, i_rdata[15:0]};
      MEM_LW:  load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      MEM_LWU: load_data = {32'b0, i_rdata[31:0]};
      default: load_data = i_rdata;
    endcase
  end

  assign o_wb_data = i_ctrl.mem_to_reg ? load_data : o_alu_result;

  // decoder must only hand over known ALU encodings
  always_comb begin
    assert (i_ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
                                  ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_COPY_IMM,
                                  ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU})
      else $error("exu: unknown alu op %0d", i_ctrl.alu_op);
  end

endmodule

// File: hdl/rv64_core.sv
// single-cycle RV64IM core top with pc and halt state, decoder, register file and execute unit
`timescale 1ns/1ps

module rv64_core import rv64_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  inst_t    i_inst,
  input  xlen_t    i_rdata,
  output xlen_t    o_pc,
  output mem_req_t o_mem_req,
  output logic     o_wb_valid,
  output reg_idx_t o_wb_rd,
  output xlen_t    o_wb_data,
  output logic     o_halt,
  output logic     o_illegal
);

  xlen_t    pc, next_pc;
  xlen_t    imm, rs1_val, rs2_val, alu_result, wb_data;
  reg_idx_t rs1, rs2, rd;
  ctrl_t    ctrl;
  logic     halted, active;

  // strobes are dropped in reset and once halted
  assign active = i_rst_n && !halted;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      // pc parks on the ebreak
      if (!halted && !ctrl.halt) begin
        pc <= next_pc;
      end
      if (ctrl.halt) begin
        halted <= 1'b1;
      end
    end
  end

  rv64_idu rv64_idu_i (
    .i_inst (i_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  rv64_regfile rv64_regfile_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_rd     (rd),
    .i_we     (o_wb_valid),
    .i_wdata  (wb_data),
    .o_rdata1 (rs1_val),
    .o_rdata2 (rs2_val)
  );

  rv64_exu rv64_exu_i (
    .i_ctrl       (ctrl),
    .i_rs1        (rs1_val),
    .i_rs2        (rs2_val),
    .i_imm        (imm),
    .i_pc         (pc),
    .i_rdata      (i_rdata),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc),
    .o_wb_data    (wb_data)
  );

  assign o_pc = pc;

  assign o_mem_req.addr  = alu_result;
  assign o_mem_req.wdata = rs2_val;
  assign o_mem_req.size  = ctrl.mem_op[2:1];
  assign o_mem_req.re    = active && ctrl.mem_read;
  assign o_mem_req.we    = active && ctrl.mem_write;

  assign o_wb_valid = active && ctrl.reg_write;
  assign o_wb_rd    = rd;
  assign o_wb_data  = wb_data;
  assign o_halt     = halted || ctrl.halt;
  assign o_illegal  = ctrl.illegal;

  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    pc[1:0] == 2'b00
  ) else $error("core: pc misaligned %h", pc);

endmodule

// File: dv/rv64_core_tb.sv
// testbench for the RV64IM core with program table, data memory, reference model and checks
`timescale 1ns/1ps

module rv64_core_tb import rv64_pkg::*; ();

  localparam int HOLD = 8;
  localparam int NGRP = 6;
  localparam logic [31:0] SEED = 32'he2c0_52d9;
  localparam logic [6:0] OP_R = 7'h33, OP_R32 = 7'h3b, OP_I = 7'h13, OP_I32 = 7'h1b;

  logic     clk, rst_n;
  inst_t    i_inst;
  xlen_t    i_rdata, o_pc, o_wb_data;
  mem_req_t o_mem_req;
  logic     o_wb_valid, o_halt, o_illegal;
  reg_idx_t o_wb_rd;

  logic [31:0] prog [0:255];
  int          grp [0:255];
  int          n_prog, cycles, errs, cur_grp, n_pass, n_fail, held;
  int          grp_errs [0:NGRP-1];
  string       grp_name [0:NGRP-1];
  logic [7:0]  dmem [0:255];
  logic [7:0]  ref_mem [0:255];
  xlen_t       mreg [0:31];
  xlen_t       mpc, e_data, e_npc, e_addr;
  logic        mhalted, e_valid, e_ill, e_halt, e_re, e_we;

  rv64_core rv64_core_i (
    .i_clk(clk), .i_rst_n(rst_n), .i_inst(i_inst), .i_rdata(i_rdata), .o_pc(o_pc),
    .o_mem_req(o_mem_req), .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd),
    .o_wb_data(o_wb_data), .o_halt(o_halt), .o_illegal(o_illegal)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // run limit scales with the program length
  always @(posedge clk) begin
    cycles++;
    if (n_prog > 0 && cycles > 2 * n_prog + 50) begin
      $display("timeout: core did not reach the end of the program after %0d cycles", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic emit(input logic [31:0] ins, input int g);
    prog[n_prog] = ins;
    grp[n_prog]  = g;
    n_prog++;
  endtask

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                        input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [31:0] fetch(input xlen_t pc);
    xlen_t idx;
    idx = (pc - RESET_PC) >> 2;
    return (idx < 64'(n_prog)) ? prog[idx] : 32'h0;
  endfunction

  // ISA rules for mul, div and rem
  function automatic logic [63:0] md64(input logic [2:0] f3, input logic [63:0] x, y);
    logic ovf;
    ovf = (x == {1'b1, 63'b0}) && (y == '1);
    case (f3)
      3'd0: return x * y;
      3'd4: if (y == 0) return '1; else if (ovf) return x; else return $signed(x) / $signed(y);
      3'd5: if (y == 0) return '1; else return x / y;
      3'd6: if (y == 0) return x; else if (ovf) return 0; else return $signed(x) % $signed(y);
      default: if (y == 0) return x; else return x % y;
    endcase
  endfunction

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt, input logic md,
                                          input logic w, input logic [63:0] x, y);
    logic [31:0] xw, yw;
    logic [5:0]  sh;
    logic [63:0] xx, yy;
    xw = x[31:0];
    yw = y[31:0];
    sh = w ? {1'b0, y[4:0]} : y[5:0];
    if (md && w) begin
      // unsigned word divide sees zero-extended operands
      xx = (f3[2] && f3[0]) ? {32'b0, xw} : sext32(xw);
      yy = (f3[2] && f3[0]) ? {32'b0, yw} : sext32(yw);
      xx = md64(f3, xx, yy);
      return sext32(xx[31:0]);
    end
    if (md) return md64(f3, x, y);
    if (w) begin
      case (f3)
        3'd0: return sext32(alt ? xw - yw : xw + yw);
        3'd1: return sext32(xw << sh);
        3'd5: return alt ? sext32($signed(xw) >>> sh) : sext32(xw >> sh);
        default: return 0;
      endcase
    end
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << sh;
      3'd2: return {63'b0, $signed(x) < $signed(y)};
      3'd3: return {63'b0, x < y};
      3'd4: return x ^ y;
      3'd5: begin
        if (alt) return $signed(x) >>> sh;
        return x >> sh;
      end
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic model_step(input logic [31:0] ins);
    logic [2:0] f3;
    xlen_t      a, b, ii, addr, v;
    logic       tk;
    f3 = ins[14:12];
    a  = mreg[ins[19:15]];
    b  = mreg[ins[24:20]];
    ii = {{52{ins[31]}}, ins[31:20]};
    e_valid = 1'b0;
    e_data  = 0;
    e_ill   = 1'b0;
    e_re    = 1'b0;
    e_we    = 1'b0;
    e_addr  = 0;
    e_halt  = mhalted;
    e_npc   = mhalted ? mpc : mpc + 4;
    if (mhalted) return;
    case (ins[6:0])
      7'h37: begin e_valid = 1; e_data = sext32({ins[31:12], 12'b0}); end
      7'h17: begin e_valid = 1; e_data = mpc + sext32({ins[31:12], 12'b0}); end
      7'h6f: begin
        e_valid = 1;
        e_data  = mpc + 4;
        e_npc   = mpc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h67: begin e_valid = 1; e_data = mpc + 4; e_npc = (a + ii) & ~64'd1; end
      7'h63: begin
        case (f3)
          3'd0: tk = (a == b);
          3'd1: tk = (a != b);
          3'd4: tk = $signed(a) < $signed(b);
          3'd5: tk = $signed(a) >= $signed(b);
          3'd6: tk = a < b;
          default: tk = a >= b;
        endcase
        if (tk) e_npc = mpc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'h03: begin
        addr = a + ii;
        for (int k = 0; k < 8; k++) v[8*k +: 8] = ref_mem[8'(addr + k)];
        e_valid = 1;
        e_re    = 1;
        e_addr  = addr;
        case (f3)
          3'd0: e_data = {{56{v[7]}}, v[7:0]};
          3'd1: e_data = {{48{v[15]}}, v[15:0]};
          3'd2: e_data = sext32(v[31:0]);
          3'd4: e_data = {56'b0, v[7:0]};
          3'd5: e_data = {48'b0, v[15:0]};
          3'd6: e_data = {32'b0, v[31:0]};
          default: e_data = v;
        endcase
      end
      7'h23: begin
        addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
        e_we   = 1;
        e_addr = addr;
        for (int k = 0; k < (1 << f3[1:0]); k++) ref_mem[8'(addr + k)] = b[8*k +: 8];
      end
      OP_I:   begin e_valid = 1; e_data = alu_ref(f3, f3 == 5 && ins[30], 0, 0, a, ii); end
      OP_I32: begin e_valid = 1; e_data = alu_ref(f3, f3 == 5 && ins[30], 0, 1, a, ii); end
      OP_R, OP_R32: begin
        e_valid = 1;
        e_data  = alu_ref(f3, ins[30], ins[25], ins[6:0] == OP_R32, a, b);
      end
      7'h73: begin e_halt = 1; e_npc = mpc; end
      default: e_ill = 1'b1;
    endcase
  endtask

  task automatic value_error(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    errs++;
    grp_errs[cur_grp]++;
  endtask

  task automatic report_group(input int g);
    if (grp_errs[g] == 0) n_pass++;
    else n_fail++;
    $display("test %0d %s: %s", g, grp_name[g], (grp_errs[g] == 0) ? "PASS" : "FAIL");
  endtask

  task automatic check_cycle();
    xlen_t       idx;
    logic [31:0] ins;
    idx = (mpc - RESET_PC) >> 2;
    if (!mhalted && idx < 64'(n_prog) && grp[idx] != cur_grp) begin
      report_group(cur_grp);
      cur_grp = grp[idx];
    end
    ins = fetch(mpc);
    model_step(ins);
    if (o_pc !== mpc) value_error($sformatf("pc %h, expected %h", o_pc, mpc));
    if (o_wb_valid !== e_valid) value_error($sformatf("wb_valid %b at pc %h", o_wb_valid, mpc));
    if (e_valid && o_wb_rd !== ins[11:7])
      value_error($sformatf("wb_rd %0d at pc %h", o_wb_rd, mpc));
    if (e_valid && o_wb_data !== e_data)
      value_error($sformatf("wb_data %h, expected %h at pc %h", o_wb_data, e_data, mpc));
    if (o_illegal !== e_ill) value_error($sformatf("illegal %b at pc %h", o_illegal, mpc));
    if (o_halt !== e_halt) value_error($sformatf("halt %b at pc %h", o_halt, mpc));
    if (o_mem_req.re !== e_re)
      value_error($sformatf("mem re %b at pc %h", o_mem_req.re, mpc));
    if (o_mem_req.we !== e_we)
      value_error($sformatf("mem we %b at pc %h", o_mem_req.we, mpc));
    if ((e_re || e_we) && o_mem_req.addr !== e_addr)
      value_error($sformatf("mem addr %h, expected %h at pc %h", o_mem_req.addr, e_addr, mpc));
    if (o_mem_req.we === 1'b1) begin
      for (int k = 0; k < (1 << o_mem_req.size); k++)
        dmem[8'(o_mem_req.addr + k)] = o_mem_req.wdata[8*k +: 8];
    end
    if (e_valid && ins[11:7] != 0) mreg[ins[11:7]] = e_data;
    if (e_halt) mhalted = 1'b1;
    mpc = e_npc;
  endtask

  task automatic drive_inputs();
    #1 i_inst = fetch(o_pc);
    #1;
    for (int k = 0; k < 8; k++) i_rdata[8*k +: 8] = dmem[8'(o_mem_req.addr + k)];
    #1;
  endtask

  task automatic build_program();
    logic [31:0] r;
    emit(enc_i(12'd5, 0, 3'd0, 0, OP_I), 0);
    emit(enc_r(7'h00, 0, 0, 3'd0, 13, OP_R), 0);
    for (int x = 1; x <= 4; x++) begin
      r = $urandom();
      emit({r[31:12], 5'(x), 7'h37}, 1);
      emit(enc_i(r[11:0], x, 3'd0, x, OP_I), 1);
    end
    emit(enc_i(12'd32, 1, 3'd1, 5, OP_I), 1);
    emit(enc_r(7'h00, 2, 5, 3'd6, 5, OP_R), 1);
    for (int f = 0; f < 8; f++) begin
      r = $urandom();
      emit(enc_r(7'h00, 2, 5, 3'(f), 14, OP_R), 1);
      if (f == 1 || f == 5) emit(enc_i({6'b0, r[5:0]}, 5, 3'(f), 14, OP_I), 1);
      else emit(enc_i(r[11:0], 1, 3'(f), 14, OP_I), 1);
    end
    emit(enc_r(7'h20, 2, 5, 3'd0, 14, OP_R), 1);
    emit(enc_r(7'h20, 3, 5, 3'd5, 14, OP_R), 1);
    emit(enc_i(12'h427, 5, 3'd5, 14, OP_I), 1);
    for (int f = 0; f < 3; f++) begin
      emit(enc_r(7'h00, 3, 5, (f == 0) ? 3'd0 : (f == 1) ? 3'd1 : 3'd5, 14, OP_R32), 1);
      emit(enc_i(12'(f * 7 + 3), 2, (f == 0) ? 3'd0 : (f == 1) ? 3'd1 : 3'd5, 14, OP_I32), 1);
    end
    emit(enc_r(7'h20, 3, 5, 3'd0, 14, OP_R32), 1);
    emit(enc_r(7'h20, 3, 5, 3'd5, 14, OP_R32), 1);
    emit(enc_i(12'h413, 2, 3'd5, 14, OP_I32), 1);
    emit(enc_i(12'd0, 0, 3'd0, 6, OP_I), 2);
    emit(enc_i(12'hfff, 0, 3'd0, 7, OP_I), 2);
    emit(enc_i(12'd1, 0, 3'd0, 8, OP_I), 2);
    emit(enc_i(12'd63, 8, 3'd1, 8, OP_I), 2);
    emit({20'h80000, 5'd9, 7'h37}, 2);
    for (int f = 0; f < 8; f++) begin
      if (f == 0 || f >= 4) begin
        emit(enc_r(7'h01, 3, 5, 3'(f), 14, OP_R), 2);
        emit(enc_r(7'h01, 6, 5, 3'(f), 14, OP_R), 2);
        emit(enc_r(7'h01, 7, 8, 3'(f), 14, OP_R), 2);
        emit(enc_r(7'h01, 3, 5, 3'(f), 14, OP_R32), 2);
        emit(enc_r(7'h01, 6, 1, 3'(f), 14, OP_R32), 2);
        emit(enc_r(7'h01, 7, 9, 3'(f), 14, OP_R32), 2);
      end
    end
    emit(enc_i(12'h100, 0, 3'd0, 10, OP_I), 3);
    emit({7'd0, 5'd5, 5'd10, 3'd3, 5'd0, 7'h23}, 3);
    emit({7'd0, 5'd3, 5'd10, 3'd2, 5'd8, 7'h23}, 3);
    emit({7'd0, 5'd4, 5'd10, 3'd1, 5'd12, 7'h23}, 3);
    emit({7'd0, 5'd2, 5'd10, 3'd0, 5'd14, 7'h23}, 3);
    for (int f = 0; f < 7; f++) begin
      emit(enc_i(12'(f * 2), 10, 3'(f), 15, 7'h03), 3);
      emit(enc_i(12'(f + 9), 10, 3'(f), 15, 7'h03), 3);
    end
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        emit(enc_b(13'd8, 1, 1, 3'(f)), 4);
        emit(enc_i(12'd1, 31, 3'd0, 31, OP_I), 4);
        emit(enc_b(13'd8, 7, 8, 3'(f)), 4);
        emit(enc_i(12'd1, 31, 3'd0, 31, OP_I), 4);
        emit(enc_b(13'd8, 8, 7, 3'(f)), 4);
        emit(enc_i(12'd1, 31, 3'd0, 31, OP_I), 4);
      end
    end
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd11, 7'h6f}, 4);
    emit(enc_i(12'd1, 31, 3'd0, 31, OP_I), 4);
    emit(enc_i(12'd13, 11, 3'd0, 12, 7'h67), 4);
    emit(enc_i(12'd1, 31, 3'd0, 31, OP_I), 4);
    emit(enc_i(12'd0, 12, 3'd0, 16, OP_I), 4);
    emit(32'h0000_0000, 5);
    emit(32'hffff_ffff, 5);
    emit(INST_EBREAK, 5);
    emit(enc_i(12'd1, 3, 3'd0, 3, OP_I), 5);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    i_inst = 32'h0;
    i_rdata = 0;
    n_prog = 0;
    cycles = 0;
    errs = 0;
    n_pass = 0;
    n_fail = 0;
    cur_grp = 0;
    held = 0;
    grp_name = '{"reset_x0", "alu", "muldiv", "load_store", "branch_jump", "illegal_halt"};
    foreach (grp_errs[g]) grp_errs[g] = 0;
    foreach (mreg[x]) mreg[x] = 0;
    for (int a = 0; a < 256; a++) begin
      dmem[a] = 8'(a * 29) ^ 8'hc3;
      ref_mem[a] = dmem[a];
    end
    void'($urandom(SEED));
    build_program();
    mpc = RESET_PC;
    mhalted = 1'b0;
    repeat (4) @(posedge clk);
    drive_inputs();
    if (o_pc !== RESET_PC || o_wb_valid !== 1'b0 || o_mem_req.we !== 1'b0)
      value_error($sformatf("reset state pc %h wb_valid %b", o_pc, o_wb_valid));
    @(posedge clk);
    #1 rst_n = 1'b1;
    i_inst = fetch(o_pc);
    #1;
    for (int k = 0; k < 8; k++) i_rdata[8*k +: 8] = dmem[8'(o_mem_req.addr + k)];
    #1 check_cycle();
    while (held < HOLD) begin
      @(posedge clk);
      drive_inputs();
      check_cycle();
      if (mhalted) held++;
    end
    report_group(cur_grp);
    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errs);
    if (errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/rv64_pkg.sv
hdl/rv64_idu.sv
hdl/rv64_regfile.sv
hdl/rv64_exu.sv
hdl/rv64_core.sv
dv/rv64_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module rv64_core_tb -o rv64_core_sim
./obj_dir/rv64_core_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
